/* all.f */
csr_pkg.sv
csr_write_arbiter.sv
csr_machine_regs.sv
csr_counters.sv
csr_read_mux.sv
csr_file.sv
csr_file_properties.sv
csr_checker.sv
tb_csr_file.sv

/* csr_checker.sv */
`timescale 1ns/100ps

module csr_checker (
    input  logic                                                              clk,
    input  logic                                                              rst,
    input  logic [csr_pkg::commit_channels-1:0][csr_pkg::csr_addr_width-1:0] commit_write_addr,
    input  logic [csr_pkg::commit_channels-1:0][csr_pkg::reg_data_width-1:0] commit_write_data,
    input  logic [csr_pkg::commit_channels-1:0]                              commit_we,
    input  logic [csr_pkg::commit_channels-1:0][csr_pkg::csr_addr_width-1:0] commit_read_addr,
    input  logic [csr_pkg::csr_addr_width-1:0]                               exc_read_addr,
    input  logic [csr_pkg::reg_data_width-1:0]                               irq_pending,
    input  logic [csr_pkg::commit_count_width-1:0]                           commit_count,
    input  logic                                                              branch_num,
    input  logic                                                              branch_hit,
    input  logic                                                              branch_miss,
    input  logic                                                              rob_full,
    input  logic [csr_pkg::reg_data_width-1:0]                               exc_read_data,
    input  logic [csr_pkg::commit_channels-1:0][csr_pkg::reg_data_width-1:0] commit_read_data,
    input  logic [csr_pkg::reg_data_width-1:0]                               mie_out,
    input  logic [csr_pkg::reg_data_width-1:0]                               mstatus_out,
    input  logic [csr_pkg::reg_data_width-1:0]                               mip_out,
    input  logic [csr_pkg::reg_data_width-1:0]                               mepc_out,
    output int                                                                check_count,
    output int                                                                error_count
);
    import csr_pkg::*;

    // Shadow copy of the architectural CSR state
    logic [31:0] mstatus;
    logic [31:0] mie;
    logic [31:0] mtvec;
    logic [31:0] mcounteren;
    logic [31:0] mscratch;
    logic [31:0] mepc;
    logic [31:0] mcause;
    logic [31:0] mtval;
    logic [31:0] mip;
    logic [63:0] mcycle;
    logic [63:0] minstret;
    logic [hpm_events-1:0][63:0] hpm;
    logic armed = 1'b0;

    initial begin
        check_count = 0;
        error_count = 0;
    end

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("** Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    function automatic logic [31:0] expected_read(input logic [csr_addr_width-1:0] addr);
        logic [63:0] count;
        int slot;
        slot = int'(addr[2:0]);
        // Counters sit at b00 to b06 with their high halves 80 hex above and a hole at b01
        if (addr[11:8] == 4'hb && addr[6:3] == 4'h0 && slot != 1 && slot != 7) begin
            case (slot)
                0: count = mcycle;
                2: count = minstret;
                default: count = hpm[slot - 3];
            endcase
            return addr[7] ? count[63:32] : count[31:0];
        end
        case (addr)
            csr_mstatus:    return mstatus;
            csr_misa:       return misa_value;
            csr_mie:        return mie;
            csr_mtvec:      return mtvec;
            csr_mcounteren: return mcounteren;
            csr_mscratch:   return mscratch;
            csr_mepc:       return mepc;
            csr_mcause:     return mcause;
            csr_mtval:      return mtval;
            csr_mip:        return mip;
            csr_marchid:    return marchid_value;
            csr_mimpid:     return mimpid_value;
            default:        return '0;
        endcase
    endfunction

    task automatic apply_write(input logic [csr_addr_width-1:0] addr, input logic [31:0] data);
        case (addr)
            csr_mstatus:    mstatus = data & mstatus_mask;
            csr_mie:        mie = data & mie_mask;
            csr_mtvec:      mtvec = data & ~32'h3;
            csr_mcounteren: mcounteren = data & mcounteren_mask;
            csr_mscratch:   mscratch = data;
            csr_mepc:       mepc = data & ~32'h3;
            csr_mcause:     mcause = data;
            csr_mtval:      mtval = data;
            csr_mcycle:     mcycle[31:0] = data;
            csr_mcycleh:    mcycle[63:32] = data;
            csr_minstret:   minstret[31:0] = data;
            csr_minstreth:  minstret[63:32] = data;
            default: ;
        endcase
    endtask

    // Outputs and inputs are both settled at the falling edge
    always @(negedge clk) begin
        if (armed) begin
            compare("exc_read_data", expected_read(exc_read_addr), exc_read_data);
            for (int ch = 0; ch < commit_channels; ch++) begin
                compare($sformatf("commit_read_data[%0d]", ch),
                        expected_read(commit_read_addr[ch]), commit_read_data[ch]);
            end
            compare("mie_out", mie, mie_out);
            compare("mstatus_out", mstatus, mstatus_out);
            compare("mip_out", mip, mip_out);
            compare("mepc_out", mepc, mepc_out);
        end
        // Advance the model to the state the next rising edge produces
        if (rst) begin
            {mstatus, mie, mtvec, mcounteren, mscratch, mepc, mcause, mtval, mip} = '0;
            mcycle = '0;
            minstret = '0;
            hpm = '0;
            armed = 1'b1;
        end else begin
            mip = irq_pending;
            mcycle = mcycle + 64'd1;
            minstret = minstret + 64'(commit_count);
            hpm[ev_branch_num] = hpm[ev_branch_num] + 64'(branch_num);
            hpm[ev_branch_hit] = hpm[ev_branch_hit] + 64'(branch_hit);
            hpm[ev_branch_miss] = hpm[ev_branch_miss] + 64'(branch_miss);
            hpm[ev_rob_full] = hpm[ev_rob_full] + 64'(rob_full);
            // Channel 0 is applied last so that it wins a collision
            for (int ch = commit_channels - 1; ch >= 0; ch--) begin
                if (commit_we[ch]) begin
                    apply_write(commit_write_addr[ch], commit_write_data[ch]);
                end
            end
        end
    end

endmodule

/* csr_counters.sv */
`timescale 1ns/100ps

module csr_counters (
    input  logic                                                              clk,
    input  logic                                                              rst,
    input  logic [csr_pkg::commit_channels-1:0][csr_pkg::csr_addr_width-1:0] commit_write_addr,
    input  logic [csr_pkg::commit_channels-1:0][csr_pkg::reg_data_width-1:0] commit_write_data,
    input  logic [csr_pkg::commit_channels-1:0]                              write_grant,
    input  logic [csr_pkg::commit_count_width-1:0]                           commit_count,
    input  logic [csr_pkg::hpm_events-1:0]                                   event_pulse,
    output logic [csr_pkg::counter_width-1:0]                                mcycle,
    output logic [csr_pkg::counter_width-1:0]                                minstret,
    output logic [csr_pkg::hpm_events-1:0][csr_pkg::counter_width-1:0]      hpm_count
);
    import csr_pkg::*;

    logic [counter_width-1:0] mcycle_next;
    logic [counter_width-1:0] minstret_next;
    logic [hpm_events-1:0][counter_width-1:0] hpm_next;

    // Each counter first takes its incremented value as one 64 bit add,
    // then a granted write replaces only the half it addresses
    always_comb begin
        mcycle_next = mcycle + counter_width'(1);
        minstret_next = minstret + counter_width'(commit_count);
        for (int ch = 0; ch < commit_channels; ch++) begin
            if (write_grant[ch]) begin
                case (commit_write_addr[ch])
                    csr_mcycle: begin
                        mcycle_next[reg_data_width-1:0] = commit_write_data[ch];
                    end
                    csr_mcycleh: begin
                        mcycle_next[counter_width-1:reg_data_width] = commit_write_data[ch];
                    end
                    csr_minstret: begin
                        minstret_next[reg_data_width-1:0] = commit_write_data[ch];
                    end
                    csr_minstreth: begin
                        minstret_next[counter_width-1:reg_data_width] = commit_write_data[ch];
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    // Event counters are read only from the software side
    always_comb begin
        for (int e = 0; e < hpm_events; e++) begin
            hpm_next[e] = hpm_count[e] + counter_width'(event_pulse[e]);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mcycle <= '0;
            minstret <= '0;
            hpm_count <= '0;
        end else begin
            mcycle <= mcycle_next;
            minstret <= minstret_next;
            hpm_count <= hpm_next;
        end
    end

endmodule

/* csr_file.sv */
`timescale 1ns/100ps

module csr_file (
    input  logic                                                              clk,
    input  logic                                                              rst,
    input  logic [csr_pkg::commit_channels-1:0][csr_pkg::csr_addr_width-1:0] commit_write_addr,
    input  logic [csr_pkg::commit_channels-1:0][csr_pkg::reg_data_width-1:0] commit_write_data,
    input  logic [csr_pkg::commit_channels-1:0]                              commit_we,
    input  logic [csr_pkg::commit_channels-1:0][csr_pkg::csr_addr_width-1:0] commit_read_addr,
    input  logic [csr_pkg::csr_addr_width-1:0]                               exc_read_addr,
    input  logic [csr_pkg::reg_data_width-1:0]                               irq_pending,
    input  logic [csr_pkg::commit_count_width-1:0]                           commit_count,
    input  logic                                                              branch_num,
    input  logic                                                              branch_hit,
    input  logic                                                              branch_miss,
    input  logic                                                              rob_full,
    output logic [csr_pkg::reg_data_width-1:0]                               exc_read_data,
    output logic [csr_pkg::commit_channels-1:0][csr_pkg::reg_data_width-1:0] commit_read_data,
    output logic [csr_pkg::reg_data_width-1:0]                               mie_out,
    output logic [csr_pkg::reg_data_width-1:0]                               mstatus_out,
    output logic [csr_pkg::reg_data_width-1:0]                               mip_out,
    output logic [csr_pkg::reg_data_width-1:0]                               mepc_out
);
    import csr_pkg::*;

    logic [commit_channels-1:0] write_grant;
    logic [hpm_events-1:0] event_pulse;
    logic [reg_data_width-1:0] mtvec;
    logic [reg_data_width-1:0] mcounteren;
    logic [reg_data_width-1:0] mscratch;
    logic [reg_data_width-1:0] mcause;
    logic [reg_data_width-1:0] mtval;
    logic [counter_width-1:0] mcycle;
    logic [counter_width-1:0] minstret;
    logic [hpm_events-1:0][counter_width-1:0] hpm_count;

    assign event_pulse[ev_branch_num] = branch_num;
    assign event_pulse[ev_branch_hit] = branch_hit;
    assign event_pulse[ev_branch_miss] = branch_miss;
    assign event_pulse[ev_rob_full] = rob_full;

    csr_write_arbiter arbiter0 (
        .commit_write_addr(commit_write_addr),
        .commit_we(commit_we),
        .write_grant(write_grant)
    );

    // The status outputs are the machine registers themselves
    csr_machine_regs machine_regs0 (
        .clk(clk),
        .rst(rst),
        .commit_write_addr(commit_write_addr),
        .commit_write_data(commit_write_data),
        .write_grant(write_grant),
        .irq_pending(irq_pending),
        .mstatus(mstatus_out),
        .mie(mie_out),
        .mtvec(mtvec),
        .mcounteren(mcounteren),
        .mscratch(mscratch),
        .mepc(mepc_out),
        .mcause(mcause),
        .mtval(mtval),
        .mip(mip_out)
    );

    csr_counters counters0 (
        .clk(clk),
        .rst(rst),
        .commit_write_addr(commit_write_addr),
        .commit_write_data(commit_write_data),
        .write_grant(write_grant),
        .commit_count(commit_count),
        .event_pulse(event_pulse),
        .mcycle(mcycle),
        .minstret(minstret),
        .hpm_count(hpm_count)
    );

    csr_read_mux read_mux0 (
        .exc_read_addr(exc_read_addr),
        .commit_read_addr(commit_read_addr),
        .mstatus(mstatus_out),
        .mie(mie_out),
        .mtvec(mtvec),
        .mcounteren(mcounteren),
        .mscratch(mscratch),
        .mepc(mepc_out),
        .mcause(mcause),
        .mtval(mtval),
        .mip(mip_out),
        .mcycle(mcycle),
        .minstret(minstret),
        .hpm_count(hpm_count),
        .exc_read_data(exc_read_data),
        .commit_read_data(commit_read_data)
    );

endmodule

/* csr_file_properties.sv */
`timescale 1ns/100ps

module csr_file_properties (
    input logic                              clk,
    input logic                              rst,
    input logic [csr_pkg::reg_data_width-1:0] irq_pending,
    input logic [csr_pkg::reg_data_width-1:0] mtvec,
    input logic [csr_pkg::reg_data_width-1:0] mepc_out,
    input logic [csr_pkg::reg_data_width-1:0] mstatus_out,
    input logic [csr_pkg::reg_data_width-1:0] mip_out,
    input logic [csr_pkg::reg_data_width-1:0] mie_out
);
    import csr_pkg::*;

    // Trap vector and return address stay word aligned
    assert property (@(posedge clk) disable iff (rst)
        (mtvec[1:0] == 2'b00) && (mepc_out[1:0] == 2'b00))
        else $error("mtvec or mepc has a low address bit set");

    assert property (@(posedge clk) disable iff (rst) (mstatus_out & ~mstatus_mask) == '0)
        else $error("mstatus holds bits outside its write mask");

    assert property (@(posedge clk) !rst |=> mip_out == $past(irq_pending))
        else $error("mip does not follow the sampled interrupt lines");

    assert property (@(posedge clk) rst |=>
        (mie_out == '0) && (mstatus_out == '0) && (mip_out == '0) && (mepc_out == '0))
        else $error("status outputs not cleared by reset");

endmodule

bind csr_file csr_file_properties props0 (
    .clk(clk),
    .rst(rst),
    .irq_pending(irq_pending),
    .mtvec(mtvec),
    .mepc_out(mepc_out),
    .mstatus_out(mstatus_out),
    .mip_out(mip_out),
    .mie_out(mie_out)
);

/* csr_machine_regs.sv */
`timescale 1ns/100ps

module csr_machine_regs (
    input  logic                                                              clk,
    input  logic                                                              rst,
    input  logic [csr_pkg::commit_channels-1:0][csr_pkg::csr_addr_width-1:0] commit_write_addr,
    input  logic [csr_pkg::commit_channels-1:0][csr_pkg::reg_data_width-1:0] commit_write_data,
    input  logic [csr_pkg::commit_channels-1:0]                              write_grant,
    input  logic [csr_pkg::reg_data_width-1:0]                               irq_pending,
    output logic [csr_pkg::reg_data_width-1:0]                               mstatus,
    output logic [csr_pkg::reg_data_width-1:0]                               mie,
    output logic [csr_pkg::reg_data_width-1:0]                               mtvec,
    output logic [csr_pkg::reg_data_width-1:0]                               mcounteren,
    output logic [csr_pkg::reg_data_width-1:0]                               mscratch,
    output logic [csr_pkg::reg_data_width-1:0]                               mepc,
    output logic [csr_pkg::reg_data_width-1:0]                               mcause,
    output logic [csr_pkg::reg_data_width-1:0]                               mtval,
    output logic [csr_pkg::reg_data_width-1:0]                               mip
);
    import csr_pkg::*;

    always_ff @(posedge clk) begin
        if (rst) begin
            mstatus <= '0;
            mie <= '0;
            mtvec <= '0;
            mcounteren <= '0;
            mscratch <= '0;
            mepc <= '0;
            mcause <= '0;
            mtval <= '0;
            mip <= '0;
        end else begin
            // Pending interrupts come straight from the interrupt controller
            mip <= irq_pending;

            // The arbiter leaves one grant per address, so channel order is irrelevant here
            for (int ch = 0; ch < commit_channels; ch++) begin
                if (write_grant[ch]) begin
                    case (commit_write_addr[ch])
                        csr_mstatus: begin
                            mstatus <= commit_write_data[ch] & mstatus_mask;
                        end
                        csr_mie: begin
                            mie <= commit_write_data[ch] & mie_mask;
                        end
                        csr_mtvec: begin
                            // Only direct mode exists and the base is word aligned
                            mtvec <= {commit_write_data[ch][reg_data_width-1:2], 2'b00};
                        end
                        csr_mcounteren: begin
                            mcounteren <= commit_write_data[ch] & mcounteren_mask;
                        end
                        csr_mscratch: begin
                            mscratch <= commit_write_data[ch];
                        end
                        csr_mepc: begin
                            mepc <= {commit_write_data[ch][reg_data_width-1:2], 2'b00};
                        end
                        csr_mcause: begin
                            mcause <= commit_write_data[ch];
                        end
                        csr_mtval: begin
                            mtval <= commit_write_data[ch];
                        end
                        default: begin
                        end
                    endcase
                end
            end
        end
    end

endmodule

/* csr_pkg.sv */
package csr_pkg;

    // Datapath and address widths
    localparam int reg_data_width = 32;
    localparam int csr_addr_width = 12;
    localparam int counter_width = 2 * reg_data_width;

    // Commit side
    localparam int commit_channels = 2;
    localparam int commit_width = 4;
    // Must hold 0 to commit_width inclusive
    localparam int commit_count_width = $clog2(commit_width) + 1;

    localparam int hpm_events = 4;

    // Misa, marchid and mimpid are the only identity registers that read nonzero
    localparam logic [reg_data_width-1:0] misa_value = 32'h4000_1100;
    localparam logic [reg_data_width-1:0] marchid_value = 32'h1998_1001;
    localparam logic [reg_data_width-1:0] mimpid_value = 32'h2022_0201;

    // Only MIE/MPIE in mstatus and the machine enables in mie are writable
    localparam logic [reg_data_width-1:0] mstatus_mask = 32'h0000_0088;
    localparam logic [reg_data_width-1:0] mie_mask = 32'h0000_0888;
    localparam logic [reg_data_width-1:0] mcounteren_mask = 32'h0000_0007;

    typedef enum logic [csr_addr_width-1:0] {
        csr_mstatus    = 12'h300,
        csr_misa       = 12'h301,
        csr_mie        = 12'h304,
        csr_mtvec      = 12'h305,
        csr_mcounteren = 12'h306,
        csr_mscratch   = 12'h340,
        csr_mepc       = 12'h341,
        csr_mcause     = 12'h342,
        csr_mtval      = 12'h343,
        csr_mip        = 12'h344,
        csr_mcycle     = 12'hb00,
        csr_minstret   = 12'hb02,
        csr_hpm3       = 12'hb03,
        csr_hpm4       = 12'hb04,
        csr_hpm5       = 12'hb05,
        csr_hpm6       = 12'hb06,
        csr_mcycleh    = 12'hb80,
        csr_minstreth  = 12'hb82,
        csr_hpm3h      = 12'hb83,
        csr_hpm4h      = 12'hb84,
        csr_hpm5h      = 12'hb85,
        csr_hpm6h      = 12'hb86,
        csr_mvendorid  = 12'hf11,
        csr_marchid    = 12'hf12,
        csr_mimpid     = 12'hf13,
        csr_mhartid    = 12'hf14
    } csr_addr_e;

    // Slot 0 feeds hpm3 and each later slot feeds the next counter
    typedef enum logic [1:0] {
        ev_branch_num  = 2'd0,
        ev_branch_hit  = 2'd1,
        ev_branch_miss = 2'd2,
        ev_rob_full    = 2'd3
    } hpm_event_e;

endpackage

/* csr_read_mux.sv */
`timescale 1ns/100ps

module csr_read_mux (
    input  logic [csr_pkg::csr_addr_width-1:0]                               exc_read_addr,
    input  logic [csr_pkg::commit_channels-1:0][csr_pkg::csr_addr_width-1:0] commit_read_addr,
    input  logic [csr_pkg::reg_data_width-1:0]                               mstatus,
    input  logic [csr_pkg::reg_data_width-1:0]                               mie,
    input  logic [csr_pkg::reg_data_width-1:0]                               mtvec,
    input  logic [csr_pkg::reg_data_width-1:0]                               mcounteren,
    input  logic [csr_pkg::reg_data_width-1:0]                               mscratch,
    input  logic [csr_pkg::reg_data_width-1:0]                               mepc,
    input  logic [csr_pkg::reg_data_width-1:0]                               mcause,
    input  logic [csr_pkg::reg_data_width-1:0]                               mtval,
    input  logic [csr_pkg::reg_data_width-1:0]                               mip,
    input  logic [csr_pkg::counter_width-1:0]                                mcycle,
    input  logic [csr_pkg::counter_width-1:0]                                minstret,
    input  logic [csr_pkg::hpm_events-1:0][csr_pkg::counter_width-1:0]      hpm_count,
    output logic [csr_pkg::reg_data_width-1:0]                               exc_read_data,
    output logic [csr_pkg::commit_channels-1:0][csr_pkg::reg_data_width-1:0] commit_read_data
);
    import csr_pkg::*;

    localparam int hi = counter_width - 1;
    localparam int lo = reg_data_width;

    function automatic logic [reg_data_width-1:0] read_csr(
        input logic [csr_addr_width-1:0] addr
    );
        case (addr)
            csr_mstatus:    return mstatus;
            csr_misa:       return misa_value;
            csr_mie:        return mie;
            csr_mtvec:      return mtvec;
            csr_mcounteren: return mcounteren;
            csr_mscratch:   return mscratch;
            csr_mepc:       return mepc;
            csr_mcause:     return mcause;
            csr_mtval:      return mtval;
            csr_mip:        return mip;
            csr_mcycle:     return mcycle[lo-1:0];
            csr_mcycleh:    return mcycle[hi:lo];
            csr_minstret:   return minstret[lo-1:0];
            csr_minstreth:  return minstret[hi:lo];
            csr_hpm3:       return hpm_count[ev_branch_num][lo-1:0];
            csr_hpm3h:      return hpm_count[ev_branch_num][hi:lo];
            csr_hpm4:       return hpm_count[ev_branch_hit][lo-1:0];
            csr_hpm4h:      return hpm_count[ev_branch_hit][hi:lo];
            csr_hpm5:       return hpm_count[ev_branch_miss][lo-1:0];
            csr_hpm5h:      return hpm_count[ev_branch_miss][hi:lo];
            csr_hpm6:       return hpm_count[ev_rob_full][lo-1:0];
            csr_hpm6h:      return hpm_count[ev_rob_full][hi:lo];
            csr_mvendorid:  return '0;
            csr_marchid:    return marchid_value;
            csr_mimpid:     return mimpid_value;
            csr_mhartid:    return '0;
            // Unimplemented addresses read as zero
            default:        return '0;
        endcase
    endfunction

    always_comb begin
        exc_read_data = read_csr(exc_read_addr);
        for (int ch = 0; ch < commit_channels; ch++) begin
            commit_read_data[ch] = read_csr(commit_read_addr[ch]);
        end
    end

endmodule

/* csr_write_arbiter.sv */
`timescale 1ns/100ps

module csr_write_arbiter (
    input  logic [csr_pkg::commit_channels-1:0][csr_pkg::csr_addr_width-1:0] commit_write_addr,
    input  logic [csr_pkg::commit_channels-1:0]                              commit_we,
    output logic [csr_pkg::commit_channels-1:0]                              write_grant
);
    import csr_pkg::*;

    // A channel loses only to a lower channel writing the same address,
    // so every address sees at most one granted write per cycle
    always_comb begin
        for (int ch = 0; ch < commit_channels; ch++) begin
            write_grant[ch] = commit_we[ch];
            for (int lo = 0; lo < ch; lo++) begin
                if (commit_we[lo] && (commit_write_addr[lo] == commit_write_addr[ch])) begin
                    write_grant[ch] = 1'b0;
                end
            end
        end
    end

endmodule

/* run.sh */
#!/bin/sh
verilator --binary --timing --assert -f all.f --top-module tb_csr_file -o tb_csr_file \
    && ./obj_dir/tb_csr_file > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "FAIL: build or simulation error"; exit 1; }
cat sim.log
grep -q "All tests passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

/* tb_csr_file.sv */
`timescale 1ns/100ps

module tb_csr_file;
    import csr_pkg::*;

    logic clk = 1'b0;
    logic rst = 1'b1;
    logic [commit_channels-1:0][csr_addr_width-1:0] commit_write_addr = '0;
    logic [commit_channels-1:0][reg_data_width-1:0] commit_write_data = '0;
    logic [commit_channels-1:0] commit_we = '0;
    logic [commit_channels-1:0][csr_addr_width-1:0] commit_read_addr = '0;
    logic [csr_addr_width-1:0] exc_read_addr = '0;
    logic [reg_data_width-1:0] irq_pending = '0;
    logic [commit_count_width-1:0] commit_count = '0;
    logic branch_num = 1'b0;
    logic branch_hit = 1'b0;
    logic branch_miss = 1'b0;
    logic rob_full = 1'b0;
    logic [reg_data_width-1:0] exc_read_data;
    logic [commit_channels-1:0][reg_data_width-1:0] commit_read_data;
    logic [reg_data_width-1:0] mie_out;
    logic [reg_data_width-1:0] mstatus_out;
    logic [reg_data_width-1:0] mip_out;
    logic [reg_data_width-1:0] mepc_out;
    int check_count;
    int error_count;
    int wait_failures = 0;
    logic [31:0] lfsr_state = 32'd13;
    logic [csr_addr_width-1:0] addr_pool[$];

    always #20 clk = ~clk;

    csr_file dut0 (.*);
    csr_checker checker0 (.*);

    // Galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    function logic [csr_addr_width-1:0] pick_addr();
        return addr_pool[take_bits(5) % addr_pool.size()];
    endfunction

    // Drives one cycle of random traffic and can aim both channels at one CSR
    task automatic drive_random(input bit collide);
        logic [csr_addr_width-1:0] addr0;
        @(posedge clk);
        addr0 = pick_addr();
        commit_write_addr[0] <= addr0;
        commit_write_addr[1] <= collide ? addr0 : pick_addr();
        commit_write_data[0] <= take_bits(32);
        commit_write_data[1] <= take_bits(32);
        commit_we <= collide ? 2'b11 : 2'(take_bits(2));
        commit_read_addr[0] <= pick_addr();
        commit_read_addr[1] <= pick_addr();
        exc_read_addr <= pick_addr();
        irq_pending <= take_bits(32);
        commit_count <= commit_count_width'(take_bits(3) % 5);
        {branch_num, branch_hit, branch_miss, rob_full} <= 4'(take_bits(4));
    endtask

    task automatic wait_checks(input int n, input int limit);
        int target;
        int cycles;
        target = check_count + n;
        cycles = 0;
        while (check_count < target && cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        if (check_count < target) begin
            $display("Checker made no new comparisons within %0d cycles", limit);
            wait_failures++;
        end
    endtask

    initial begin
        csr_addr_e a;
        a = a.first();
        for (int i = 0; i < a.num(); i++) begin
            addr_pool.push_back(a);
            a = a.next();
        end
        // Addresses outside the map read as zero and drop writes
        addr_pool.push_back(12'h000);
        addr_pool.push_back(12'h7c0);
        addr_pool.push_back(12'hb07);

        repeat (2) @(posedge clk);
        rst <= 1'b0;
        wait_checks(1, 10);

        foreach (addr_pool[i]) begin
            @(posedge clk);
            exc_read_addr <= addr_pool[i];
            commit_read_addr[0] <= addr_pool[i];
            commit_read_addr[1] <= addr_pool[i];
        end
        repeat (400) drive_random(1'b0);
        repeat (100) drive_random(1'b1);

        // All ones in the low halves make the next increment carry into the high halves
        @(posedge clk);
        commit_write_addr[0] <= csr_mcycle;
        commit_write_addr[1] <= csr_minstret;
        commit_write_data <= '1;
        commit_we <= 2'b11;
        commit_count <= commit_count_width'(1);
        exc_read_addr <= csr_mcycleh;
        commit_read_addr[0] <= csr_minstreth;
        commit_read_addr[1] <= csr_mcycle;
        @(posedge clk);
        commit_we <= '0;
        wait_checks(2, 10);

        repeat (200) drive_random(1'b0);
        wait_checks(1, 10);

        $display("Checks: %0d, errors: %0d, timeouts: %0d", check_count, error_count,
                 wait_failures);
        if (error_count == 0 && wait_failures == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule
